/* bht_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface bht_if #(
  parameter int bht_entries = 256
);

  localparam int idx_w = $clog2(bht_entries);

  // two read ports, one for the fetch lookup and one for the resolve update
  logic [idx_w-1:0]     raddr_fetch;
  logic [idx_w-1:0]     raddr_update;
  bp_pkg::counter_state rstate_fetch;
  bp_pkg::counter_state rstate_update;

  logic                 wen;
  logic [idx_w-1:0]     waddr;
  bp_pkg::counter_state wstate;

  modport controller (
    output raddr_fetch, raddr_update, wen, waddr, wstate,
    input  rstate_fetch, rstate_update
  );

  modport store (
    input  raddr_fetch, raddr_update, wen, waddr, wstate,
    output rstate_fetch, rstate_update
  );

endinterface

`default_nettype wire

/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

  //////////////////////////////////////////////////
  // shared widths
  //////////////////////////////////////////////////

  localparam int xlen = 32;  // address and data width of the core

  //////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////

  // upper bit set means the branch is predicted taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_state;

  typedef enum logic {
    idle    = 1'b0,  // no lookup waiting for its result
    pending = 1'b1   // a lookup was captured and is answered this cycle
  } lookup_state;

endpackage

`default_nettype wire

/* branch_predictor.f */
bp_pkg.sv
btb_if.sv
bht_if.sv
target_buffer.sv
history_table.sv
predict_control.sv
branch_predictor.sv
tb_branch_predictor.sv

/* branch_predictor.sv */
`default_nettype none
`timescale 1ns/1ps

module branch_predictor #(
  parameter int btb_entries = 64,
  parameter int bht_entries = 256
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    fetch_valid,
  input  logic [bp_pkg::xlen-1:0] fetch_pc,
  input  logic                    resolve_valid,
  input  logic [bp_pkg::xlen-1:0] resolve_pc,
  input  logic [bp_pkg::xlen-1:0] resolve_npc,
  input  logic                    resolve_taken,
  input  logic [bp_pkg::xlen-1:0] resolve_target,
  input  logic                    resolve_pred_taken,
  input  logic [bp_pkg::xlen-1:0] resolve_pred_target,
  output logic                    pred_valid,
  output logic                    pred_taken,
  output logic [bp_pkg::xlen-1:0] pred_target,
  output logic                    redirect_valid,
  output logic [bp_pkg::xlen-1:0] redirect_pc
);

  btb_if #(.btb_entries(btb_entries)) i_btb_bus ();
  bht_if #(.bht_entries(bht_entries)) i_bht_bus ();

  target_buffer #(.btb_entries(btb_entries)) i_target_buffer (
    .clock (clock),
    .reset (reset),
    .bus   (i_btb_bus.buffer)
  );

  history_table #(.bht_entries(bht_entries)) i_history_table (
    .clock (clock),
    .reset (reset),
    .bus   (i_bht_bus.store)
  );

  predict_control #(
    .btb_entries (btb_entries),
    .bht_entries (bht_entries)
  ) i_predict_control (
    .clock               (clock),
    .reset               (reset),
    .flush               (flush),
    .fetch_valid         (fetch_valid),
    .fetch_pc            (fetch_pc),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_npc         (resolve_npc),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .pred_valid          (pred_valid),
    .pred_taken          (pred_taken),
    .pred_target         (pred_target),
    .redirect_valid      (redirect_valid),
    .redirect_pc         (redirect_pc),
    .btb                 (i_btb_bus.controller),
    .bht                 (i_bht_bus.controller)
  );

endmodule

`default_nettype wire

/* btb_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface btb_if #(
  parameter int btb_entries = 64
);

  localparam int idx_w = $clog2(btb_entries);
  localparam int tag_w = bp_pkg::xlen - idx_w - 1;  // pc bit 0 is never part of index or tag

  logic [idx_w-1:0]        raddr;
  logic                    rvalid;
  logic [tag_w-1:0]        rtag;
  logic [bp_pkg::xlen-1:0] rtarget;

  logic                    wen;
  logic [idx_w-1:0]        waddr;
  logic [tag_w-1:0]        wtag;
  logic [bp_pkg::xlen-1:0] wtarget;

  modport controller (
    output raddr, wen, waddr, wtag, wtarget,
    input  rvalid, rtag, rtarget
  );

  modport buffer (
    input  raddr, wen, waddr, wtag, wtarget,
    output rvalid, rtag, rtarget
  );

endinterface

`default_nettype wire

/* history_table.sv */
`default_nettype none
`timescale 1ns/1ps

module history_table #(
  parameter int bht_entries = 256
) (
  input  logic         clock,
  input  logic         reset,
  bht_if.store         bus
);

  localparam int idx_w = $clog2(bht_entries);

  //////////////////////////////////////////////////
  // counter array
  //////////////////////////////////////////////////

  bp_pkg::counter_state counters [bht_entries];

  // every counter starts weakly not taken so one taken resolve flips it
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < bht_entries; i++) begin
        counters[i] <= bp_pkg::weak_not_taken;
      end
    end else if (bus.wen) begin
      counters[bus.waddr] <= bus.wstate;
    end
  end

  //////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////

  logic [idx_w-1:0] fetch_idx;
  logic [idx_w-1:0] update_idx;

  assign fetch_idx  = bus.raddr_fetch;
  assign update_idx = bus.raddr_update;

  // the update port sees a write from the previous edge, so resolves chain
  assign bus.rstate_fetch  = counters[fetch_idx];
  assign bus.rstate_update = counters[update_idx];

endmodule

`default_nettype wire

/* predict_control.sv */
`default_nettype none
`timescale 1ns/1ps

module predict_control #(
  parameter int btb_entries = 64,
  parameter int bht_entries = 256
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    fetch_valid,
  input  logic [bp_pkg::xlen-1:0] fetch_pc,
  input  logic                    resolve_valid,
  input  logic [bp_pkg::xlen-1:0] resolve_pc,
  input  logic [bp_pkg::xlen-1:0] resolve_npc,
  input  logic                    resolve_taken,
  input  logic [bp_pkg::xlen-1:0] resolve_target,
  input  logic                    resolve_pred_taken,
  input  logic [bp_pkg::xlen-1:0] resolve_pred_target,
  output logic                    pred_valid,
  output logic                    pred_taken,
  output logic [bp_pkg::xlen-1:0] pred_target,
  output logic                    redirect_valid,
  output logic [bp_pkg::xlen-1:0] redirect_pc,
  btb_if.controller               btb,
  bht_if.controller               bht
);

  localparam int btb_idx_w = $clog2(btb_entries);
  localparam int bht_idx_w = $clog2(bht_entries);

  //////////////////////////////////////////////////
  // lookup stage
  //////////////////////////////////////////////////

  bp_pkg::lookup_state     state_q;
  bp_pkg::lookup_state     state_d;
  logic [bp_pkg::xlen-1:0] lookup_pc_q;
  logic                    tag_hit;

  assign state_d = (fetch_valid && !flush) ? bp_pkg::pending : bp_pkg::idle;  // flush drops it

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= bp_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      lookup_pc_q <= fetch_pc;
    end
  end

  // arrays are read in the output cycle from the captured pc
  assign btb.raddr       = lookup_pc_q[btb_idx_w:1];
  assign bht.raddr_fetch = lookup_pc_q[bht_idx_w:1];

  assign tag_hit     = btb.rvalid && (btb.rtag == lookup_pc_q[bp_pkg::xlen-1:btb_idx_w+1]);
  assign pred_valid  = (state_q == bp_pkg::pending);
  assign pred_taken  = pred_valid && tag_hit && bht.rstate_fetch[1];
  assign pred_target = pred_taken ? btb.rtarget : '0;

  //////////////////////////////////////////////////
  // resolve updates
  //////////////////////////////////////////////////

  bp_pkg::counter_state next_state;

  always_comb begin
    next_state = bht.rstate_update;
    case (bht.rstate_update)
      bp_pkg::strong_not_taken:
        next_state = resolve_taken ? bp_pkg::weak_not_taken : bp_pkg::strong_not_taken;
      bp_pkg::weak_not_taken:
        next_state = resolve_taken ? bp_pkg::weak_taken : bp_pkg::strong_not_taken;
      bp_pkg::weak_taken:
        next_state = resolve_taken ? bp_pkg::strong_taken : bp_pkg::weak_not_taken;
      bp_pkg::strong_taken:
        next_state = resolve_taken ? bp_pkg::strong_taken : bp_pkg::weak_taken;
      default:
        next_state = bp_pkg::weak_not_taken;
    endcase
  end

  assign bht.raddr_update = resolve_pc[bht_idx_w:1];
  assign bht.wen          = resolve_valid;
  assign bht.waddr        = resolve_pc[bht_idx_w:1];
  assign bht.wstate       = next_state;

  assign btb.wen     = resolve_valid && resolve_taken;  // only taken branches get a target
  assign btb.waddr   = resolve_pc[btb_idx_w:1];
  assign btb.wtag    = resolve_pc[bp_pkg::xlen-1:btb_idx_w+1];
  assign btb.wtarget = resolve_target;

  //////////////////////////////////////////////////
  // redirect
  //////////////////////////////////////////////////

  logic dir_miss;
  logic target_miss;

  assign dir_miss    = resolve_taken != resolve_pred_taken;
  assign target_miss = resolve_taken && resolve_pred_taken &&
                       (resolve_target != resolve_pred_target);

  always_ff @(posedge clock) begin
    if (!reset) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= resolve_valid && (dir_miss || target_miss);
    end
  end

  always_ff @(posedge clock) begin
    if (resolve_valid) begin
      redirect_pc <= resolve_taken ? resolve_target : resolve_npc;
    end
  end

endmodule

`default_nettype wire

/* target_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module target_buffer #(
  parameter int btb_entries = 64
) (
  input  logic         clock,
  input  logic         reset,
  btb_if.buffer        bus
);

  localparam int idx_w = $clog2(btb_entries);
  localparam int tag_w = bp_pkg::xlen - idx_w - 1;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  logic [tag_w-1:0]        tag_mem    [btb_entries];
  logic [bp_pkg::xlen-1:0] target_mem [btb_entries];
  logic [btb_entries-1:0]  valid_q;

  // a write marks its entry valid until the next reset
  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else if (bus.wen) begin
      valid_q[bus.waddr] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.wen) begin
      tag_mem[bus.waddr]    <= bus.wtag;
      target_mem[bus.waddr] <= bus.wtarget;
    end
  end

  //////////////////////////////////////////////////
  // combinational read port
  //////////////////////////////////////////////////

  assign bus.rvalid  = valid_q[bus.raddr];
  assign bus.rtag    = tag_mem[bus.raddr];
  assign bus.rtarget = target_mem[bus.raddr];

endmodule

`default_nettype wire

/* tb_branch_predictor.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_branch_predictor;

  localparam time clk_period = 40ns;
  localparam int  num_steps  = 20;

  typedef struct packed {
    logic        flush;
    logic        fetch;
    logic        resolve;
    logic [31:0] pc;
    logic [31:0] npc;
    logic        taken;
    logic [31:0] target;
    logic        p_taken;  // what the pipeline had predicted for this branch
    logic [31:0] p_target;
    logic        e_valid;
    logic        e_taken;
    logic [31:0] e_target;
    logic        e_redirect;
    logic [31:0] e_redirect_pc;
  } step_t;

  logic        clock;
  logic        reset;
  logic        flush;
  logic        fetch_valid;
  logic [31:0] fetch_pc;
  logic        resolve_valid;
  logic [31:0] resolve_pc;
  logic [31:0] resolve_npc;
  logic        resolve_taken;
  logic [31:0] resolve_target;
  logic        resolve_pred_taken;
  logic [31:0] resolve_pred_target;
  logic        pred_valid;
  logic        pred_taken;
  logic [31:0] pred_target;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  step_t steps     [num_steps];
  string step_name [num_steps];
  int    step_count;

  branch_predictor #(
    .btb_entries (64),
    .bht_entries (256)
  ) i_branch_predictor (
    .clock               (clock),
    .reset               (reset),
    .flush               (flush),
    .fetch_valid         (fetch_valid),
    .fetch_pc            (fetch_pc),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_npc         (resolve_npc),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .pred_valid          (pred_valid),
    .pred_taken          (pred_taken),
    .pred_target         (pred_target),
    .redirect_valid      (redirect_valid),
    .redirect_pc         (redirect_pc)
  );

  always #(clk_period / 2) clock = ~clock;

  //////////////////////////////////////////////////
  // step table and helpers
  //////////////////////////////////////////////////

  task automatic add_step(input string name, input logic fl, input logic fe, input logic rs,
                          input logic [31:0] pc, input logic [31:0] npc, input logic tk,
                          input logic [31:0] tgt, input logic ptk, input logic [31:0] ptgt,
                          input logic ev, input logic et, input logic [31:0] etgt,
                          input logic er, input logic [31:0] erpc);
    steps[step_count] = '{fl, fe, rs, pc, npc, tk, tgt, ptk, ptgt, ev, et, etgt, er, erpc};
    step_name[step_count] = name;
    step_count++;
  endtask

  task automatic drive_step(input step_t s);
    flush               <= s.flush;
    fetch_valid         <= s.fetch;
    fetch_pc            <= s.pc;
    resolve_valid       <= s.resolve;
    resolve_pc          <= s.pc;
    resolve_npc         <= s.npc;
    resolve_taken       <= s.taken;
    resolve_target      <= s.target;
    resolve_pred_taken  <= s.p_taken;
    resolve_pred_target <= s.p_target;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: test %s, %s expected 0x%08h actual 0x%08h", name, what, expected, actual);
      $display("test failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // pc 0x1000 and 0x1200 share both indices but not the tag
  task automatic build_table();
    step_count = 0;
    add_step("reset_lookup",       0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("reset_lookup_other", 0, 1, 0, 32'h2468, 32'h246c, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("first_taken",        0, 0, 1, 32'h1000, 32'h1004, 1, 32'h4000, 0, 0,
             0, 0, 0, 1, 32'h4000);
    add_step("lookup_trained",     0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 1, 32'h4000, 0, 0);
    add_step("second_taken",       0, 0, 1, 32'h1000, 32'h1004, 1, 32'h4000, 1, 32'h4000,
             0, 0, 0, 0, 0);
    add_step("first_not_taken",    0, 0, 1, 32'h1000, 32'h1004, 0, 0, 1, 32'h4000,
             0, 0, 0, 1, 32'h1004);
    add_step("lookup_hysteresis",  0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 1, 32'h4000, 0, 0);
    add_step("second_not_taken",   0, 0, 1, 32'h1000, 32'h1004, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("lookup_not_taken",   0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("retrain_taken",      0, 0, 1, 32'h1000, 32'h1004, 1, 32'h4000, 0, 0,
             0, 0, 0, 1, 32'h4000);
    add_step("lookup_alias",       0, 1, 0, 32'h1200, 32'h1204, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("lookup_owner",       0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 1, 32'h4000, 0, 0);
    add_step("wrong_target",       0, 0, 1, 32'h1000, 32'h1004, 1, 32'h5000, 1, 32'h4000,
             0, 0, 0, 1, 32'h5000);
    add_step("correct_not_taken",  0, 0, 1, 32'h3010, 32'h3014, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("flush_lookup",       1, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("flush_resolve",      1, 0, 1, 32'h1000, 32'h1004, 0, 0, 1, 32'h5000,
             0, 0, 0, 1, 32'h1004);
    add_step("lookup_after_flush", 0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 1, 32'h5000, 0, 0);
    add_step("flush_resolve_hit",  1, 0, 1, 32'h1000, 32'h1004, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("lookup_flush_update", 0, 1, 0, 32'h1000, 32'h1004, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("idle",               0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    step_t idle_step;
    step_t s;
    idle_step = '0;
    clock = 1'b0;
    reset = 1'b0;
    drive_step(idle_step);
    build_table();
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    for (int i = 0; i <= num_steps; i++) begin
      @(posedge clock);
      if (i < num_steps) drive_step(steps[i]);
      else drive_step(idle_step);
      @(negedge clock);  // results of the previous step are stable here
      if (i > 0) begin
        s = steps[i-1];
        check_value(step_name[i-1], "pred_valid", s.e_valid, pred_valid);
        check_value(step_name[i-1], "pred_taken", s.e_taken, pred_taken);
        check_value(step_name[i-1], "pred_target", s.e_target, pred_target);
        check_value(step_name[i-1], "redirect_valid", s.e_redirect, redirect_valid);
        if (s.e_redirect) check_value(step_name[i-1], "redirect_pc", s.e_redirect_pc, redirect_pc);
      end
    end
    $display("test passed");
    $finish;
  end

  initial begin
    #(clk_period * (num_steps * 4 + 20));
    $display("watchdog expired before the step table was applied to the end");
    $display("test failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire
